// File: pow_top.f
+incdir+hdl
hdl/pow_pkg.sv
hdl/seq_multiplier.sv
hdl/pow_engine.sv
hdl/pow_apb_regs.sv
hdl/pow_top.sv
dv/pow_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the power unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f pow_top.f --top-module pow_tb -o pow_sim \
    && ./obj_dir/pow_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run unsuccessful"; exit 1; }

// File: dv/pow_tb.sv
// Power unit testbench
`timescale 1ns/10ps
`default_nettype none
`include "pow_cfg.svh"

module pow_tb;
    logic                   clk;
    logic                   reset;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`POW_ADDR_W-1:0] paddr;
    logic [`POW_DATA_W-1:0] pwdata;
    logic [`POW_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   irq;

    // Expected values, armed by the tasks and sampled by the assertions
    logic        xfer_chk;          // Access cycle of any transfer
    logic        err_exp;
    logic        rd_chk;
    logic [31:0] rd_exp;
    logic        irq_chk;
    logic        irq_exp;

    int          errors;
    int          checks;
    int          tests;
    int          budget;            // Watchdog limit in cycles
    logic [15:0] rnd_base [20];
    logic [15:0] rnd_exp  [20];
    // Three zero exponents, then negative bases with odd and even exponents
    logic [15:0] dir_base [8] = '{16'd0, 16'd5, 16'hFFF9, 16'hFFFD, 16'hFFFD,
                                  16'hFFFE, 16'h8000, 16'hFFFF};
    logic [15:0] dir_exp  [8] = '{16'd0, 16'd0, 16'd0, 16'd3, 16'd4, 16'd15, 16'd2, 16'd7};

    pow_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;         // 100 ns period
        end
    end

    a_prdata: assert property (@(posedge clk) disable iff (reset) rd_chk |-> prdata == rd_exp)
        else begin
            errors++;
            $display("[FAIL] %0t prdata expected %h got %h", $time, rd_exp, prdata);
        end
    a_pslverr: assert property (@(posedge clk) disable iff (reset)
        xfer_chk |-> pslverr == err_exp)
        else begin
            errors++;
            $display("[FAIL] %0t pslverr expected %b got %b", $time, err_exp, pslverr);
        end
    a_pready: assert property (@(posedge clk) disable iff (reset) xfer_chk |-> pready)
        else begin
            errors++;
            $display("[FAIL] %0t pready expected 1 got %b", $time, pready);
        end
    a_irq: assert property (@(posedge clk) disable iff (reset) irq_chk |-> irq == irq_exp)
        else begin
            errors++;
            $display("[FAIL] %0t irq expected %b got %b", $time, irq_exp, irq);
        end

    // Base to the power e, two's complement, wrapped to 32 bits
    function automatic logic [31:0] ref_pow(input logic [15:0] b, input logic [15:0] e);
        logic [31:0] r;
        r = 32'd1;
        for (int i = 0; i < int'(e); i++) begin
            r = r * {{16{b[15]}}, b};
        end
        return r;
    endfunction

    function automatic int test_cycles(input logic [15:0] e);
        return (int'(e) + 1) * 20 + 40;     // Run time plus APB overhead
    endfunction

    // One APB transfer, called 10 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [`POW_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic err, input logic chk,
                            input logic [31:0] rd_value, output logic [31:0] rdata);
        psel    = 1'b1;                     // Setup cycle
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #10;
        penable  = 1'b1;                    // Access cycle
        xfer_chk = 1'b1;
        err_exp  = err;
        rd_chk   = chk && !wr;
        rd_exp   = rd_value;
        checks  += rd_chk ? 3 : 2;
        @(posedge clk);
        while (!pready) begin               // Wait states, none expected
            @(posedge clk);
        end
        #10;
        rdata    = prdata;                  // Settled, access still driven
        psel     = 1'b0;
        penable  = 1'b0;
        xfer_chk = 1'b0;
        rd_chk   = 1'b0;
    endtask

    task automatic apb_write(input logic [`POW_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, err, 1'b0, '0, unused);
    endtask

    task automatic apb_read(input logic [`POW_ADDR_W-1:0] addr, input logic [31:0] value);
        logic [31:0] unused;
        apb_xfer(1'b0, addr, '0, 1'b0, 1'b1, value, unused);
    endtask

    // Poll STATUS.done, bounded by the exponent
    task automatic wait_done(input logic [15:0] e);
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < test_cycles(e) / 2) begin
            apb_xfer(1'b0, `POW_REG_STATUS, '0, 1'b0, 1'b0, '0, status);
            polls++;
        end
        if (!status[1]) begin
            errors++;
            $display("Engine did not report done after %0d status polls at %0t", polls, $time);
        end
    endtask

    task automatic run_pow(input logic [15:0] b, input logic [15:0] e, input logic ien);
        apb_write(`POW_REG_BASE, {16'h0, b}, 1'b0);
        apb_write(`POW_REG_EXP, {16'h0, e}, 1'b0);
        apb_write(`POW_REG_CTRL, {29'h0, ien, 2'b01}, 1'b0);        // Start
        wait_done(e);
        apb_read(`POW_REG_STATUS, {29'h0, ien, 2'b10});             // Done set, busy clear
        apb_read(`POW_REG_RESULT, ref_pow(b, e));
    endtask

    task automatic check_irq(input logic value);
        irq_chk = 1'b1;
        irq_exp = value;
        checks++;
        @(posedge clk);
        #10;
        irq_chk = 1'b0;
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        $display("%-20s %s", name, (errors == mark) ? "ok" : "errors");
    endtask

    initial begin : watchdog
        wait (budget != 0);
        repeat (budget) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", budget);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] unused;
        int          mark;
        int          total;
        void'($urandom(77045));
        {reset, psel, penable, pwrite} = 4'b1000;
        paddr    = '0;
        pwdata   = '0;
        {xfer_chk, err_exp, rd_chk, irq_chk, irq_exp} = '0;
        rd_exp   = '0;
        {errors, checks, tests, budget} = '0;
        total    = 400;                                     // Reset and margin
        for (int i = 0; i < 20; i++) begin
            rnd_base[i] = 16'($urandom);
            rnd_exp[i]  = 16'(1 + $urandom % 12);
            total      += test_cycles(rnd_exp[i]);
        end
        for (int i = 0; i < 8; i++) begin
            total += test_cycles(dir_exp[i]);
        end
        budget = total + test_cycles(6) + 2 * test_cycles(2) + 20;  // Busy, irq, unmapped
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        mark = errors;
        for (int i = 0; i < 3; i++) begin
            run_pow(dir_base[i], dir_exp[i], 1'b0);
        end
        report_test("exponent zero", mark);

        mark = errors;
        for (int i = 0; i < 20; i++) begin
            run_pow(rnd_base[i], rnd_exp[i], 1'b0);
        end
        report_test("random operands", mark);

        mark = errors;
        for (int i = 3; i < 8; i++) begin
            run_pow(dir_base[i], dir_exp[i], 1'b0);
        end
        report_test("negative bases", mark);

        mark = errors;
        apb_write(`POW_REG_BASE, 32'd3, 1'b0);
        apb_write(`POW_REG_EXP, 32'd6, 1'b0);
        apb_write(`POW_REG_CTRL, 32'h1, 1'b0);
        apb_write(`POW_REG_BASE, 32'd7, 1'b1);                  // Refused while busy
        apb_write(`POW_REG_EXP, 32'd2, 1'b1);
        apb_write(`POW_REG_CTRL, 32'h1, 1'b1);                  // Second start refused
        wait_done(16'd6);
        apb_read(`POW_REG_BASE, 32'd3);
        apb_read(`POW_REG_EXP, 32'd6);
        apb_read(`POW_REG_RESULT, ref_pow(16'd3, 16'd6));
        report_test("busy refusal", mark);

        mark = errors;
        apb_write(5'h14, 32'h1, 1'b1);
        apb_write(5'h1C, 32'h1, 1'b1);
        apb_xfer(1'b0, 5'h18, '0, 1'b1, 1'b1, '0, unused);     // Read of a hole
        report_test("unmapped offsets", mark);

        mark = errors;
        run_pow(16'd5, 16'd2, 1'b0);
        check_irq(1'b0);                                        // Masked
        run_pow(16'hFFFC, 16'd2, 1'b1);
        check_irq(1'b1);
        apb_write(`POW_REG_CTRL, 32'h6, 1'b0);                  // Clear done, keep enable
        apb_read(`POW_REG_STATUS, 32'h4);
        check_irq(1'b0);
        report_test("interrupt", mark);

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/pow_top.sv
// Power unit top level
`timescale 1ns/10ps
`default_nettype none
`include "pow_cfg.svh"

module pow_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire logic [`POW_ADDR_W-1:0] paddr,
    input  wire logic [`POW_DATA_W-1:0] pwdata,
    output logic      [`POW_DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        irq         // Level, done and enabled
);
    import pow_pkg::*;

    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    pow_req_t pow_req;                              // Registers to engine
    pow_rsp_t pow_rsp;                              // Engine to registers

    // Bundle the APB pins
    assign apb_req = '{psel: psel, penable: penable, pwrite: pwrite,
                       paddr: paddr, pwdata: pwdata};

    assign prdata  = apb_rsp.prdata;
    assign pready  = apb_rsp.pready;
    assign pslverr = apb_rsp.pslverr;

    pow_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .req     (pow_req),
        .rsp     (pow_rsp),
        .irq     (irq)
    );

    pow_engine u_engine (
        .clk   (clk),
        .reset (reset),
        .req   (pow_req),
        .rsp   (pow_rsp)
    );

endmodule

`default_nettype wire

// File: hdl/pow_apb_regs.sv
// Power unit APB registers
`timescale 1ns/10ps
`default_nettype none
`include "pow_cfg.svh"

module pow_apb_regs (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire pow_pkg::apb_req_t apb_req,
    output pow_pkg::apb_rsp_t      apb_rsp,
    output pow_pkg::pow_req_t      req,         // To engine
    input  wire pow_pkg::pow_rsp_t rsp,         // From engine
    output logic                   irq          // Done and irq enable
);
    // CTRL bit positions
    localparam int START_BIT = 0;
    localparam int CLR_BIT   = 1;
    localparam int IRQEN_BIT = 2;

    logic                   access;             // APB access phase
    logic                   sel_base;
    logic                   sel_exp;
    logic                   sel_ctrl;
    logic                   sel_status;
    logic                   sel_result;
    logic                   mapped;
    logic                   busy_any;           // Engine busy or start in flight
    logic                   locked;             // Refused write
    logic                   wr_ok;              // Write that takes effect

    logic [`POW_BASE_W-1:0] base_q;
    logic [`POW_EXP_W-1:0]  exp_q;
    logic                   irq_en_q;
    logic                   done_q;             // Sticky done
    logic                   start_q;            // Start pulse to engine
    logic [`POW_ACC_W-1:0]  result_q;

    assign access     = apb_req.psel && apb_req.penable;
    assign sel_base   = (apb_req.paddr == `POW_ADDR_W'(`POW_REG_BASE));
    assign sel_exp    = (apb_req.paddr == `POW_ADDR_W'(`POW_REG_EXP));
    assign sel_ctrl   = (apb_req.paddr == `POW_ADDR_W'(`POW_REG_CTRL));
    assign sel_status = (apb_req.paddr == `POW_ADDR_W'(`POW_REG_STATUS));
    assign sel_result = (apb_req.paddr == `POW_ADDR_W'(`POW_REG_RESULT));
    assign mapped     = sel_base || sel_exp || sel_ctrl || sel_status || sel_result;

    // start_q covers the cycle before the engine raises busy
    assign busy_any = rsp.busy || start_q;
    assign locked   = busy_any && access && apb_req.pwrite &&
                      (sel_base || sel_exp || (sel_ctrl && apb_req.pwdata[START_BIT]));
    assign wr_ok    = access && apb_req.pwrite && mapped && !locked;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            base_q   <= '0;
            exp_q    <= '0;
            irq_en_q <= 1'b0;
            done_q   <= 1'b0;
            start_q  <= 1'b0;
        end else begin
            start_q <= wr_ok && sel_ctrl && apb_req.pwdata[START_BIT];   // Self-clearing
            if (wr_ok && sel_base) begin
                base_q <= apb_req.pwdata[`POW_BASE_W-1:0];
            end
            if (wr_ok && sel_exp) begin
                exp_q <= apb_req.pwdata[`POW_EXP_W-1:0];
            end
            if (wr_ok && sel_ctrl) begin
                irq_en_q <= apb_req.pwdata[IRQEN_BIT];      // Every CTRL write sets it
            end
            // Set wins over clear, a new start also clears
            if (rsp.done) begin
                done_q <= 1'b1;
            end else if (wr_ok && sel_ctrl &&
                         (apb_req.pwdata[CLR_BIT] || apb_req.pwdata[START_BIT])) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.done) begin
            result_q <= rsp.result;                 // Capture on done pulse
        end
    end

    // Read mux, zero outside read access
    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && (!mapped || locked);
        if (access && !apb_req.pwrite) begin
            if (sel_base) begin
                apb_rsp.prdata = `POW_DATA_W'(base_q);          // Zero-extended
            end else if (sel_exp) begin
                apb_rsp.prdata = `POW_DATA_W'(exp_q);
            end else if (sel_status) begin
                apb_rsp.prdata = `POW_DATA_W'({irq_en_q, done_q, busy_any});
            end else if (sel_result) begin
                apb_rsp.prdata = result_q;
            end
        end
    end

    assign req.start = start_q;
    assign req.base  = base_q;
    assign req.exp   = exp_q;
    assign irq       = done_q && irq_en_q;

    a_pready_high: assert property (@(posedge clk) disable iff (reset)
        apb_rsp.pready);
    a_start_busy: assert property (@(posedge clk) disable iff (reset)
        req.start |=> rsp.busy);

endmodule

`default_nettype wire

// File: hdl/pow_engine.sv
// Power engine
`timescale 1ns/10ps
`default_nettype none
`include "pow_cfg.svh"

module pow_engine (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire pow_pkg::pow_req_t req,         // Start, base, exponent
    output pow_pkg::pow_rsp_t      rsp          // Busy, done, result
);
    import pow_pkg::*;

    pow_state_e             state;
    logic [`POW_EXP_W-1:0]  remaining;          // Multiplies still to launch
    logic [`POW_BASE_W-1:0] base_q;             // Latched base, signed bits
    logic [`POW_ACC_W-1:0]  acc_q;              // Running power, modulo 2^32

    logic                   mul_start;
    logic                   mul_done;
    logic [`POW_ACC_W-1:0]  mul_product;

    // Launch from LOAD only, multiplier is idle there
    assign mul_start = (state == LOAD) && (remaining != '0);

    seq_multiplier u_mul (
        .clk          (clk),
        .reset        (reset),
        .start        (mul_start),
        .multiplicand (acc_q),                  // Full 32-bit feedback
        .multiplier   (base_q),
        .done         (mul_done),
        .product      (mul_product)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req.start) begin
                        state     <= LOAD;
                        remaining <= req.exp;
                    end
                end
                LOAD: begin
                    if (remaining == '0) begin
                        state <= DONE;          // Exponent used up, or zero from start
                    end else begin
                        state <= MUL;           // mul_start issued this cycle
                    end
                end
                MUL: begin
                    if (mul_done) begin
                        state     <= LOAD;
                        remaining <= remaining - 1'b1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Accumulator starts at 1 so exponent 0 yields 1
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req.start) begin
            base_q <= req.base;
            acc_q  <= `POW_ACC_W'(1);
        end else if ((state == MUL) && mul_done) begin
            acc_q <= mul_product;               // Low 32 bits only
        end
    end

    always_comb begin
        rsp.busy   = (state == LOAD) || (state == MUL);   // Low in the done cycle
        rsp.done   = (state == DONE);
        rsp.result = acc_q;
    end

    // A start outside IDLE would be dropped
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        req.start |-> (state == IDLE));
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        rsp.done |=> !rsp.done);
    a_mul_done_in_mul: assert property (@(posedge clk) disable iff (reset)
        mul_done |-> (state == MUL));

endmodule

`default_nettype wire

// File: hdl/seq_multiplier.sv
// Shift-add multiplier
`timescale 1ns/10ps
`default_nettype none
`include "pow_cfg.svh"

module seq_multiplier (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   start,          // One-cycle launch
    input  wire logic [`POW_ACC_W-1:0]  multiplicand,   // Modulo 2^32 operand
    input  wire logic [`POW_BASE_W-1:0] multiplier,     // Signed 16-bit operand
    output logic                        done,           // 16 cycles after start
    output logic [`POW_ACC_W-1:0]       product         // Low 32 product bits
);
    localparam int               CNT_W    = $clog2(`POW_BASE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`POW_BASE_W - 1);

    logic                   running;        // Steps 1 to 15 pending
    logic [CNT_W-1:0]       bit_cnt;        // Multiplier bit handled this cycle
    logic [`POW_ACC_W-1:0]  mcand_q;        // Multiplicand, shifted left each step
    logic [`POW_BASE_W-1:0] mplier_q;       // Multiplier, shifted right each step
    logic [`POW_ACC_W-1:0]  acc_q;          // Partial product

    logic [`POW_ACC_W-1:0]  step_acc;
    logic [`POW_ACC_W-1:0]  step_mcand;
    logic [`POW_BASE_W-1:0] step_mplier;
    logic                   step_sign;      // Sign bit step
    logic [`POW_ACC_W-1:0]  step_sum;

    // Bit 0 is handled in the start cycle itself so done lands on cycle 16
    always_comb begin
        step_acc    = start ? '0 : acc_q;
        step_mcand  = start ? multiplicand : mcand_q;
        step_mplier = start ? multiplier : mplier_q;
        // Multiplier MSB weighs -2^15 in two's complement
        step_sign   = !start && (bit_cnt == LAST_BIT);
        if (!step_mplier[0]) begin
            step_sum = step_acc;
        end else if (step_sign) begin
            step_sum = step_acc - step_mcand;
        end else begin
            step_sum = step_acc + step_mcand;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;                               // Pulse only
            if (start) begin
                running <= 1'b1;
                bit_cnt <= CNT_W'(1);                   // Bit 0 already taken
            end else if (running) begin
                bit_cnt <= bit_cnt + 1'b1;              // Wraps back to 0 at the end
                if (bit_cnt == LAST_BIT) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Operand and partial product path
    always_ff @(posedge clk) begin
        if (start || running) begin
            acc_q    <= step_sum;
            mcand_q  <= step_mcand << 1;
            mplier_q <= step_mplier >> 1;
        end
    end

    assign product = acc_q;                             // Held until next start

    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        start |-> !running);
    a_fixed_latency: assert property (@(posedge clk) disable iff (reset)
        start |-> ##(`POW_BASE_W) done);

endmodule

`default_nettype wire

// File: hdl/pow_pkg.sv
// Power unit shared types
`default_nettype none
`include "pow_cfg.svh"

package pow_pkg;

    // Register block to engine
    typedef struct packed {
        logic                          start;   // One-cycle launch pulse
        logic signed [`POW_BASE_W-1:0] base;    // Two's-complement base
        logic        [`POW_EXP_W-1:0]  exp;     // Exponent, unsigned
    } pow_req_t;

    // Engine to register block
    typedef struct packed {
        logic                  busy;            // Run in progress
        logic                  done;            // One-cycle end pulse
        logic [`POW_ACC_W-1:0] result;          // Valid from done to next start
    } pow_rsp_t;

    // APB master side, bundled at the top level
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`POW_ADDR_W-1:0] paddr;
        logic [`POW_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`POW_DATA_W-1:0] prdata;
        logic                   pready;         // Tied high, no wait states
        logic                   pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {IDLE, LOAD, MUL, DONE} pow_state_e;

endpackage

`default_nettype wire

// File: hdl/pow_cfg.svh
// Power unit configuration
`ifndef POW_CFG_SVH
`define POW_CFG_SVH

// Datapath widths
`define POW_BASE_W 16           // Signed base operand
`define POW_EXP_W  16           // Unsigned exponent
`define POW_ACC_W  32           // Accumulator and result, wraps modulo 2^32
`define POW_DATA_W 32           // APB data bus
`define POW_ADDR_W 5            // APB byte address

// Register byte offsets
`define POW_REG_BASE   'h00     // Base, R/W
`define POW_REG_EXP    'h04     // Exponent, R/W
`define POW_REG_CTRL   'h08     // Start, clear done, irq enable, W/O
`define POW_REG_STATUS 'h0C     // Busy, done, irq enable, R/O
`define POW_REG_RESULT 'h10     // Last result, R/O

`endif
